// ==== logic/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// window and lane geometry
`define CONV_TAPS 9
`define CONV_LANES 4

// memory and counter widths
`define CONV_ADDR_W 16
`define CONV_DIM_W 6
`define CONV_CH_W 10

// nine 2-bit codebook indices per weight word
`define CONV_CODE_W 18

// output requantization
`define CONV_QSHIFT 5
`define CONV_QMAX 127

`endif

// ==== logic/conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

  typedef logic signed [7:0]  pixel_t;
  typedef logic signed [7:0]  weight_t;
  typedef logic signed [15:0] acc_t;
  typedef logic [31:0]        bias_t;

  typedef logic [`CONV_CODE_W/`CONV_TAPS-1:0] code_t;
  // one signed byte per code value
  typedef logic [(2**$bits(code_t))*$bits(weight_t)-1:0] codebook_t;

  typedef logic [`CONV_ADDR_W-1:0] addr_t;
  typedef logic [`CONV_DIM_W-1:0]  dim_t;
  typedef logic [`CONV_CH_W-1:0]   chan_t;

  typedef enum logic [2:0] {
    ph_idle,
    ph_load_bias,
    ph_load_weight,
    ph_fetch,
    ph_calc,
    ph_write,
    ph_done
  } phase_e;

endpackage

// ==== logic/conv_step_if.sv ====
`timescale 1ns/1ps

interface conv_step_if;
  import conv_pkg::*;

  phase_e     phase;
  logic [3:0] step;
  dim_t       x;
  dim_t       y;
  chan_t      cha;
  // base kernel of the current lane group
  chan_t      ker;
  logic       first_cha;
  logic       last_cha;
  dim_t       num_row;
  chan_t      num_channel;

  modport ctrl (output phase, step, x, y, cha, ker, first_cha, last_cha,
                       num_row, num_channel);

  modport unit (input phase, step, x, y, cha, ker, first_cha, last_cha,
                      num_row, num_channel);

endinterface

// ==== logic/conv_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_ctrl (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,
  input  conv_pkg::dim_t  num_row,
  input  conv_pkg::chan_t num_channel,
  input  conv_pkg::chan_t num_kernel,
  conv_step_if.ctrl       step_bus,
  output logic            finish
);
  import conv_pkg::*;

  phase_e     phase;
  phase_e     phase_nxt;
  logic [3:0] step;
  logic [3:0] last_step;
  logic       phase_end;
  dim_t       x;
  dim_t       y;
  chan_t      cha;
  chan_t      ker;
  dim_t       n_row;
  chan_t      n_ch;
  chan_t      n_ker;
  logic       last_x;
  logic       last_pixel;
  logic       last_cha;
  logic       last_group;

  always_comb begin
    case (phase)
      ph_load_bias, ph_load_weight: last_step = 4'd4;
      ph_fetch:                     last_step = 4'd9;
      ph_write:                     last_step = 4'd11;
      default:                      last_step = 4'd0;
    endcase
  end

  assign phase_end  = (step == last_step);
  assign last_x     = (x == n_row - 1'b1);
  assign last_pixel = last_x && (y == n_row - 1'b1);
  assign last_cha   = (cha == n_ch - 1'b1);
  assign last_group = (ker == n_ker - chan_t'(`CONV_LANES));

  always_comb begin
    phase_nxt = phase;
    case (phase)
      ph_idle:        if (start) phase_nxt = ph_load_bias;
      ph_load_bias:   if (phase_end) phase_nxt = ph_load_weight;
      ph_load_weight: if (phase_end) phase_nxt = ph_fetch;
      ph_fetch:       if (phase_end) phase_nxt = ph_calc;
      ph_calc:        phase_nxt = ph_write;
      ph_write: begin
        if (phase_end) begin
          // x innermost, then y, then channel, then kernel group
          if (!last_pixel) phase_nxt = ph_fetch;
          else if (!last_cha) phase_nxt = ph_load_weight;
          else if (!last_group) phase_nxt = ph_load_bias;
          else phase_nxt = ph_done;
        end
      end
      default:        phase_nxt = ph_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase <= ph_idle;
      step  <= '0;
      x     <= '0;
      y     <= '0;
      cha   <= '0;
      ker   <= '0;
      n_row <= '0;
      n_ch  <= '0;
      n_ker <= '0;
    end else begin
      phase <= phase_nxt;
      step  <= phase_end ? '0 : step + 1'b1;
      if (phase == ph_idle && start) begin
        n_row <= num_row;
        n_ch  <= num_channel;
        n_ker <= num_kernel;
        x     <= '0;
        y     <= '0;
        cha   <= '0;
        ker   <= '0;
      end else if (phase == ph_write && phase_end) begin
        x <= last_x ? '0 : x + 1'b1;
        if (last_x) begin
          y <= last_pixel ? '0 : y + 1'b1;
        end
        if (last_pixel) begin
          cha <= last_cha ? '0 : cha + 1'b1;
          if (last_cha) begin
            ker <= ker + chan_t'(`CONV_LANES);
          end
        end
      end
    end
  end

  assign step_bus.phase       = phase;
  assign step_bus.step        = step;
  assign step_bus.x           = x;
  assign step_bus.y           = y;
  assign step_bus.cha         = cha;
  assign step_bus.ker         = ker;
  assign step_bus.first_cha   = (cha == '0);
  assign step_bus.last_cha    = last_cha;
  assign step_bus.num_row     = n_row;
  assign step_bus.num_channel = n_ch;

  assign finish = (phase == ph_done);

endmodule

// ==== logic/window_fetch.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module window_fetch (
  input  logic             clk,
  input  logic             rstn,
  conv_step_if.unit        step_bus,
  output logic             input_cs,
  output conv_pkg::addr_t  input_addr,
  input  conv_pkg::pixel_t input_rdata,
  output conv_pkg::pixel_t taps [`CONV_TAPS]
);
  import conv_pkg::*;

  localparam int PW = `CONV_DIM_W + 1;

  logic [1:0]    off_r;
  logic [1:0]    off_c;
  logic [PW-1:0] row_p1;
  logic [PW-1:0] col_p1;
  logic [PW-1:0] side;
  logic          in_image;
  dim_t          row;
  dim_t          col;
  addr_t         plane;
  logic          hit_q;
  logic [3:0]    cap_idx;

  // tap t sits at window offset (t/3, t%3)
  // positions kept one above the pixel index
  assign off_r  = 2'(step_bus.step / 4'd3);
  assign off_c  = 2'(step_bus.step % 4'd3);
  assign row_p1 = PW'(step_bus.y) + PW'(off_r);
  assign col_p1 = PW'(step_bus.x) + PW'(off_c);
  assign side   = PW'(step_bus.num_row);

  assign in_image = (row_p1 != '0) && (col_p1 != '0) &&
                    (row_p1 <= side) && (col_p1 <= side);

  assign row   = dim_t'(row_p1 - 1'b1);
  assign col   = dim_t'(col_p1 - 1'b1);
  assign plane = addr_t'(step_bus.cha) * addr_t'(step_bus.num_row) * addr_t'(step_bus.num_row);

  assign input_cs   = (step_bus.phase == ph_fetch) &&
                      (step_bus.step < 4'(`CONV_TAPS)) && in_image;
  assign input_addr = plane + addr_t'(row) * addr_t'(step_bus.num_row) + addr_t'(col);

  // data for the previous step's tap arrives now
  assign cap_idx = step_bus.step - 1'b1;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= input_cs;
    end
  end

  // padded taps had no request and load zero
  always_ff @(posedge clk) begin
    if (step_bus.phase == ph_fetch && step_bus.step != 4'd0) begin
      for (int t = 0; t < `CONV_TAPS; t++) begin
        if (cap_idx == 4'(t)) begin
          taps[t] <= hit_q ? input_rdata : '0;
        end
      end
    end
  end

endmodule

// ==== logic/kernel_store.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module kernel_store (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start,
  input  conv_pkg::codebook_t     codebook,
  conv_step_if.unit               step_bus,
  output logic                    bias_cs,
  output logic                    weight_cs,
  output conv_pkg::addr_t         bias_addr,
  output conv_pkg::addr_t         weight_addr,
  input  conv_pkg::bias_t         bias_rdata,
  input  logic [`CONV_CODE_W-1:0] weight_rdata,
  output conv_pkg::weight_t       lane_weights [`CONV_LANES][`CONV_TAPS],
  output conv_pkg::acc_t          lane_bias [`CONV_LANES]
);
  import conv_pkg::*;

  codebook_t  book;
  logic       bias_req_q;
  logic       weight_req_q;
  logic [3:0] cap_idx;
  chan_t      kernel;

  function automatic weight_t decode(input code_t code, input codebook_t cb);
    return weight_t'(cb[code*$bits(weight_t) +: $bits(weight_t)]);
  endfunction

  // one request per lane at steps 0..3
  assign kernel    = step_bus.ker + chan_t'(step_bus.step);
  assign bias_cs   = (step_bus.phase == ph_load_bias) && (step_bus.step < 4'(`CONV_LANES));
  assign weight_cs = (step_bus.phase == ph_load_weight) && (step_bus.step < 4'(`CONV_LANES));

  assign bias_addr   = addr_t'(kernel);
  assign weight_addr = addr_t'(kernel) * addr_t'(step_bus.num_channel) + addr_t'(step_bus.cha);

  assign cap_idx = step_bus.step - 1'b1;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      book         <= '0;
      bias_req_q   <= 1'b0;
      weight_req_q <= 1'b0;
    end else begin
      bias_req_q   <= bias_cs;
      weight_req_q <= weight_cs;
      if (start && step_bus.phase == ph_idle) begin
        book <= codebook;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < `CONV_LANES; l++) begin
      if (cap_idx == 4'(l)) begin
        if (bias_req_q) begin
          lane_bias[l] <= acc_t'(bias_rdata);
        end
        if (weight_req_q) begin
          for (int t = 0; t < `CONV_TAPS; t++) begin
            lane_weights[l][t] <= decode(weight_rdata[t*$bits(code_t) +: $bits(code_t)], book);
          end
        end
      end
    end
  end

endmodule

// ==== logic/pe_array.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module pe_array (
  input  logic              clk,
  input  logic              rstn,
  conv_step_if.unit         step_bus,
  input  conv_pkg::pixel_t  taps [`CONV_TAPS],
  input  conv_pkg::weight_t lane_weights [`CONV_LANES][`CONV_TAPS],
  output conv_pkg::acc_t    lane_sums [`CONV_LANES]
);
  import conv_pkg::*;

  acc_t dot [`CONV_LANES];

  // products and running sum both wrap at 16 bits
  always_comb begin
    for (int l = 0; l < `CONV_LANES; l++) begin
      dot[l] = '0;
      for (int t = 0; t < `CONV_TAPS; t++) begin
        dot[l] = dot[l] + acc_t'(taps[t]) * acc_t'(lane_weights[l][t]);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lane_sums <= '{default: '0};
    end else if (step_bus.phase == ph_calc) begin
      lane_sums <= dot;
    end
  end

endmodule

// ==== logic/output_writer.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module output_writer (
  input  logic            clk,
  input  logic            rstn,
  conv_step_if.unit       step_bus,
  input  conv_pkg::acc_t  lane_sums [`CONV_LANES],
  input  conv_pkg::acc_t  lane_bias [`CONV_LANES],
  output logic            output_cs,
  output logic            output_we,
  output conv_pkg::addr_t output_addr,
  output conv_pkg::acc_t  output_wdata,
  input  conv_pkg::acc_t  output_rdata
);
  import conv_pkg::*;

  localparam int LW = $clog2(`CONV_LANES);

  logic [LW-1:0] lane;
  logic [1:0]    slot;
  logic          in_write;
  chan_t         kernel;
  addr_t         n_sq;
  acc_t          sum;
  acc_t          wdata_q;

  // relu, then saturate, then drop the fraction bits
  function automatic acc_t quantize(input acc_t v);
    if (v[$bits(acc_t)-1]) begin
      return '0;
    end
    if (|v[$bits(acc_t)-1:`CONV_QSHIFT+7]) begin
      return acc_t'(`CONV_QMAX);
    end
    return acc_t'(v[`CONV_QSHIFT+7:`CONV_QSHIFT]);
  endfunction

  // read, compute and write take one step each per lane
  assign in_write = (step_bus.phase == ph_write);
  assign lane     = LW'(step_bus.step / 4'd3);
  assign slot     = 2'(step_bus.step % 4'd3);
  assign kernel   = step_bus.ker + chan_t'(lane);
  assign n_sq     = addr_t'(step_bus.num_row) * addr_t'(step_bus.num_row);

  assign output_addr = addr_t'(kernel) * n_sq +
                       addr_t'(step_bus.y) * addr_t'(step_bus.num_row) + addr_t'(step_bus.x);
  assign output_cs   = in_write && (slot != 2'd1);
  assign output_we   = in_write && (slot == 2'd2);

  // first channel starts from the bias, later ones from the stored partial
  assign sum = lane_sums[lane] + (step_bus.first_cha ? lane_bias[lane] : output_rdata);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wdata_q <= '0;
    end else if (in_write && slot == 2'd1) begin
      wdata_q <= step_bus.last_cha ? quantize(sum) : sum;
    end
  end

  assign output_wdata = wdata_q;

endmodule

// ==== logic/conv3x3_top.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv3x3_top (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start,
  input  conv_pkg::codebook_t     codebook,
  input  conv_pkg::dim_t          num_row,
  input  conv_pkg::chan_t         num_channel,
  input  conv_pkg::chan_t         num_kernel,
  output logic                    finish,
  output logic                    bias_cs,
  output conv_pkg::addr_t         bias_addr,
  input  conv_pkg::bias_t         bias_rdata,
  output logic                    weight_cs,
  output conv_pkg::addr_t         weight_addr,
  input  logic [`CONV_CODE_W-1:0] weight_rdata,
  output logic                    input_cs,
  output conv_pkg::addr_t         input_addr,
  input  conv_pkg::pixel_t        input_rdata,
  output logic                    output_cs,
  output logic                    output_we,
  output conv_pkg::addr_t         output_addr,
  output conv_pkg::acc_t          output_wdata,
  input  conv_pkg::acc_t          output_rdata
);
  import conv_pkg::*;

  pixel_t  taps [`CONV_TAPS];
  weight_t lane_weights [`CONV_LANES][`CONV_TAPS];
  acc_t    lane_bias [`CONV_LANES];
  acc_t    lane_sums [`CONV_LANES];

  conv_step_if step_bus ();

  conv_ctrl u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .start       (start),
    .num_row     (num_row),
    .num_channel (num_channel),
    .num_kernel  (num_kernel),
    .step_bus    (step_bus.ctrl),
    .finish      (finish)
  );

  window_fetch u_window (
    .clk         (clk),
    .rstn        (rstn),
    .step_bus    (step_bus.unit),
    .input_cs    (input_cs),
    .input_addr  (input_addr),
    .input_rdata (input_rdata),
    .taps        (taps)
  );

  kernel_store u_kernel (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .codebook     (codebook),
    .step_bus     (step_bus.unit),
    .bias_cs      (bias_cs),
    .weight_cs    (weight_cs),
    .bias_addr    (bias_addr),
    .weight_addr  (weight_addr),
    .bias_rdata   (bias_rdata),
    .weight_rdata (weight_rdata),
    .lane_weights (lane_weights),
    .lane_bias    (lane_bias)
  );

  pe_array u_pe (
    .clk          (clk),
    .rstn         (rstn),
    .step_bus     (step_bus.unit),
    .taps         (taps),
    .lane_weights (lane_weights),
    .lane_sums    (lane_sums)
  );

  output_writer u_writer (
    .clk          (clk),
    .rstn         (rstn),
    .step_bus     (step_bus.unit),
    .lane_sums    (lane_sums),
    .lane_bias    (lane_bias),
    .output_cs    (output_cs),
    .output_we    (output_we),
    .output_addr  (output_addr),
    .output_wdata (output_wdata),
    .output_rdata (output_rdata)
  );

endmodule

// ==== test/conv_checker.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_checker #(
  parameter int MEM_SIZE = 256
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,
  input  logic            finish,
  input  logic            output_cs,
  input  logic            output_we,
  input  conv_pkg::addr_t output_addr,
  input  conv_pkg::acc_t  output_wdata,
  input  conv_pkg::acc_t  expected [MEM_SIZE],
  input  int              num_out,
  input  int              exp_cycles,
  output int              data_errors,
  output int              timing_errors
);
  import conv_pkg::*;

  acc_t shadow [MEM_SIZE];
  logic busy;
  logic finish_q;
  int   cycles;

  task automatic compare_outputs();
    for (int a = 0; a < num_out; a++) begin
      if (shadow[a] !== expected[a]) begin
        $display("Mismatch at %0t: output_mem[%0d] got %0d expected %0d",
                 $time, a, shadow[a], expected[a]);
        data_errors++;
      end
    end
  endtask

  // values sampled at the edge belong to the cycle just ended
  always @(posedge clk) begin
    if (!rstn) begin
      busy          = 1'b0;
      finish_q      = 1'b0;
      cycles        = 0;
      data_errors   = 0;
      timing_errors = 0;
    end else begin
      if (output_cs && output_we && int'(output_addr) < MEM_SIZE) begin
        shadow[int'(output_addr)] = output_wdata;
      end
      if (busy) begin
        cycles++;
      end
      if (finish) begin
        if (finish_q) begin
          $display("finish stayed high for more than one cycle at %0t", $time);
          timing_errors++;
        end else if (!busy) begin
          $display("finish pulsed at %0t while no job was running", $time);
          timing_errors++;
        end else begin
          if (cycles != exp_cycles) begin
            $display("Mismatch at %0t: finish cycle got %0d expected %0d",
                     $time, cycles, exp_cycles);
            timing_errors++;
          end
          compare_outputs();
          busy = 1'b0;
        end
      end else if (busy && cycles > exp_cycles) begin
        $display("finish never came within %0d cycles of start", exp_cycles);
        timing_errors++;
        busy = 1'b0;
      end
      if (start) begin
        busy   = 1'b1;
        cycles = 0;
        // stale pattern so a missing write shows up
        for (int a = 0; a < MEM_SIZE; a++) begin
          shadow[a] = 16'h5a00 ^ 16'(a);
        end
      end
      finish_q = finish;
    end
  end

endmodule

// ==== test/tb_conv3x3.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module tb_conv3x3;
  import conv_pkg::*;

  localparam int          AW       = 8;
  localparam int          MEM_SIZE = 2 ** AW;
  localparam logic [31:0] SEED     = 32'hcf5c_dbf2;

  function automatic int run_cycles(input int n, input int c, input int k);
    return 1 + (k / `CONV_LANES) * (5 + c * (5 + 23 * n * n));
  endfunction

  // two single-channel jobs and two three-channel jobs
  localparam int CYCLE_LIMIT = 2 * run_cycles(4, 1, 4) + 2 * run_cycles(5, 3, 8) + 200;

  logic                    clk = 1'b0;
  logic                    rstn;
  logic                    start;
  codebook_t               codebook;
  dim_t                    num_row;
  chan_t                   num_channel;
  chan_t                   num_kernel;
  logic                    finish;
  logic                    bias_cs;
  addr_t                   bias_addr;
  bias_t                   bias_rdata = '0;
  logic                    weight_cs;
  addr_t                   weight_addr;
  logic [`CONV_CODE_W-1:0] weight_rdata = '0;
  logic                    input_cs;
  addr_t                   input_addr;
  pixel_t                  input_rdata = '0;
  logic                    output_cs;
  logic                    output_we;
  addr_t                   output_addr;
  acc_t                    output_wdata;
  acc_t                    output_rdata = '0;

  pixel_t                  input_mem [MEM_SIZE];
  logic [`CONV_CODE_W-1:0] weight_mem [MEM_SIZE];
  bias_t                   bias_mem [MEM_SIZE];
  acc_t                    out_mem [MEM_SIZE];
  acc_t                    expected [MEM_SIZE];
  int                      num_out;
  int                      exp_cycles;
  logic [31:0]             seed;
  int                      cycle_count = 0;
  int                      other_errors;
  int                      data_errors;
  int                      timing_errors;

  always #20 clk = ~clk;

  conv3x3_top uut (.*);

  conv_checker #(.MEM_SIZE(MEM_SIZE)) u_checker (.*);

  task automatic check_range(input string name, input logic cs, input addr_t addr);
    if (cs && int'(addr) >= MEM_SIZE) begin
      $display("%s request to address %0d lies outside the modeled memory at %0t",
               name, addr, $time);
      other_errors++;
    end
  endtask

  // synchronous memories with data one cycle after the request
  always @(posedge clk) begin : mem_model
    logic        b_cs;
    logic        w_cs;
    logic        i_cs;
    logic        o_cs;
    logic        o_we;
    addr_t       b_addr;
    addr_t       w_addr;
    addr_t       i_addr;
    addr_t       o_addr;
    acc_t        o_wdata;
    b_cs    = bias_cs;
    w_cs    = weight_cs;
    i_cs    = input_cs;
    o_cs    = output_cs;
    o_we    = output_we;
    b_addr  = bias_addr;
    w_addr  = weight_addr;
    i_addr  = input_addr;
    o_addr  = output_addr;
    o_wdata = output_wdata;
    check_range("bias", b_cs, b_addr);
    check_range("weight", w_cs, w_addr);
    check_range("input", i_cs, i_addr);
    check_range("output", o_cs, o_addr);
    #1;
    if (b_cs) bias_rdata = bias_mem[b_addr[AW-1:0]];
    if (w_cs) weight_rdata = weight_mem[w_addr[AW-1:0]];
    if (i_cs) input_rdata = input_mem[i_addr[AW-1:0]];
    if (o_cs && o_we) begin
      out_mem[o_addr[AW-1:0]] = o_wdata;
    end else if (o_cs) begin
      output_rdata = out_mem[o_addr[AW-1:0]];
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic acc_t ref_output(input int k, input int y, input int x, input int n,
                                      input int c, input codebook_t cb);
    int                      total;
    int                      r;
    int                      q;
    int                      p;
    int                      code;
    logic [`CONV_CODE_W-1:0] w;
    acc_t                    v;
    total = int'($signed(bias_mem[k][15:0]));
    for (int ch = 0; ch < c; ch++) begin
      w = weight_mem[k * c + ch];
      for (int t = 0; t < `CONV_TAPS; t++) begin
        r = y + t / 3 - 1;
        q = x + t % 3 - 1;
        p = 0;
        if (r >= 0 && r < n && q >= 0 && q < n) p = int'(input_mem[ch * n * n + r * n + q]);
        code = int'(w[2 * t +: 2]);
        total += p * int'($signed(cb[8 * code +: 8]));
      end
    end
    // one wrap at the end matches the per-channel 16-bit wrap
    v = acc_t'(total);
    if (v < 0) return '0;
    if (int'(v) >= (1 << (`CONV_QSHIFT + 7))) return acc_t'(`CONV_QMAX);
    return acc_t'(int'(v) >> `CONV_QSHIFT);
  endfunction

  task automatic fill_memories();
    for (int a = 0; a < MEM_SIZE; a++) begin
      seed = lcg_next(seed);
      // six-bit pixels keep many sums inside the quantizer range
      input_mem[a] = {{2{seed[29]}}, seed[29:24]};
      seed = lcg_next(seed);
      weight_mem[a] = seed[31:14];
      seed = lcg_next(seed);
      bias_mem[a] = {seed[31:16], {4{seed[11]}}, seed[11:0]};
      out_mem[a] = 16'h3c00 ^ 16'(a);
    end
  endtask

  task automatic set_large_biases();
    for (int k = 0; k < `CONV_LANES; k++) begin
      seed = lcg_next(seed);
      // even kernels far above saturation and odd ones far below zero
      bias_mem[k][15:0] = (k % 2 == 0) ? {4'h4, seed[27:16]} : {4'hc, seed[27:16]};
    end
  endtask

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("Mismatch at %0t: %s got %b expected 0", $time, name, value);
      other_errors++;
    end
  endtask

  task automatic check_quiet();
    expect_low("finish", finish);
    expect_low("bias_cs", bias_cs);
    expect_low("weight_cs", weight_cs);
    expect_low("input_cs", input_cs);
    expect_low("output_cs", output_cs);
    expect_low("output_we", output_we);
  endtask

  task automatic run_job(input int n, input int c, input int k, input codebook_t cb);
    for (int kk = 0; kk < k; kk++) begin
      for (int y = 0; y < n; y++) begin
        for (int x = 0; x < n; x++) begin
          expected[kk * n * n + y * n + x] = ref_output(kk, y, x, n, c, cb);
        end
      end
    end
    num_out     = k * n * n;
    exp_cycles  = run_cycles(n, c, k);
    num_row     = dim_t'(n);
    num_channel = chan_t'(c);
    num_kernel  = chan_t'(k);
    codebook    = cb;
    start       = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // dimensions and codebook only count at start
    codebook    = ~cb;
    num_row     = '0;
    num_channel = '0;
    num_kernel  = '0;
    while (finish !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    // give the checker the finish edge before the next job
    repeat (3) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic print_counts();
    $display("errors: data %0d, finish timing %0d, other %0d",
             data_errors, timing_errors, other_errors);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a job never completed", CYCLE_LIMIT);
      print_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    codebook_t cb;
    rstn         = 1'b0;
    start        = 1'b0;
    codebook     = '0;
    num_row      = '0;
    num_channel  = '0;
    num_kernel   = '0;
    num_out      = 0;
    exp_cycles   = 0;
    other_errors = 0;
    seed         = SEED;
    fill_memories();
    repeat (10) begin
      @(posedge clk);
      #1;
      check_quiet();
    end
    rstn = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #1;
      check_quiet();
    end
    seed = lcg_next(seed);
    cb   = seed;
    run_job(4, 1, 4, cb);
    run_job(5, 3, 8, cb);
    // same memories with a fresh codebook
    seed = lcg_next(seed);
    cb   = seed;
    run_job(5, 3, 8, cb);
    // small codebook {2, -1, 1, -2} so the bias dominates
    set_large_biases();
    run_job(4, 1, 4, 32'hfe01_ff02);
    print_counts();
    if (data_errors + timing_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+logic
logic/conv_pkg.sv
logic/conv_step_if.sv
logic/conv_ctrl.sv
logic/window_fetch.sv
logic/kernel_store.sv
logic/pe_array.sv
logic/output_writer.sv
logic/conv3x3_top.sv
test/conv_checker.sv
test/tb_conv3x3.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_conv3x3
RTL_TOP   ?= conv3x3_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
